// File: src/log_char_pkg.sv
package log_char_pkg;

    ////////////////////////////////////////
    // Character classes
    ////////////////////////////////////////

    // Codes follow the reference type numbering, other at the end
    typedef enum logic [3:0] {
        cc_caret      = 4'd0,
        cc_dec_digit  = 4'd1,
        cc_at         = 4'd2,
        cc_hex_letter = 4'd3,
        cc_space      = 4'd4,
        cc_star       = 4'd5,
        cc_equals     = 4'd6,
        cc_less       = 4'd7,
        cc_dollar     = 4'd8,
        cc_hash       = 4'd9,
        cc_colon      = 4'd10,
        cc_other      = 4'd11
    } char_class_e;

    ////////////////////////////////////////
    // Classifier to parser token
    ////////////////////////////////////////

    // Nibble holds the digit value, zero for non-digit classes
    typedef struct packed {
        char_class_e char_class;
        logic [3:0]  nibble;
    } char_token_t;

endpackage

// File: src/log_record_pkg.sv
package log_record_pkg;

    // Field limits
    localparam int DEC_FIELD_MAX_DIGITS = 4;
    localparam int HEX_FIELD_DIGITS     = 8;
    localparam int TIME_WIDTH           = 14;

    ////////////////////////////////////////
    // Parser output
    ////////////////////////////////////////

    typedef enum logic [2:0] {
        field_none   = 3'd0,
        field_time   = 3'd1,
        field_pc     = 3'd2,
        field_target = 3'd3,
        field_data   = 3'd4
    } field_sel_e;

    // Same 2-bit codes as the reference format_type output
    typedef enum logic [1:0] {
        kind_none      = 2'd0,
        kind_reg_write = 2'd1,
        kind_mem_write = 2'd2
    } record_kind_e;

    typedef struct packed {
        logic         start;
        field_sel_e   field;
        logic [3:0]   nibble;
        logic         done;
        record_kind_e kind;
    } parse_step_t;

    ////////////////////////////////////////
    // Decoded line
    ////////////////////////////////////////

    typedef struct packed {
        record_kind_e          kind;
        logic [TIME_WIDTH-1:0] time_value;
        logic [31:0]           pc;
        logic [31:0]           target;
        logic [31:0]           data;
    } log_record_t;

endpackage

// File: src/char_classifier.sv
module char_classifier (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [7:0]                char,
    output log_char_pkg::char_token_t token
);

    log_char_pkg::char_token_t token_next;

    ////////////////////////////////////////
    // Byte decode
    ////////////////////////////////////////

    always_comb begin
        token_next.char_class = log_char_pkg::cc_other;
        token_next.nibble     = 4'd0;
        case (char) inside
            "^": token_next.char_class = log_char_pkg::cc_caret;
            ["0":"9"]: begin
                token_next.char_class = log_char_pkg::cc_dec_digit;
                // ASCII digits carry their value in the low nibble
                token_next.nibble     = char[3:0];
            end
            "@": token_next.char_class = log_char_pkg::cc_at;
            ["a":"f"]: begin
                token_next.char_class = log_char_pkg::cc_hex_letter;
                // "a" is 0x61, so low nibble plus nine
                token_next.nibble     = char[3:0] + 4'd9;
            end
            " ": token_next.char_class = log_char_pkg::cc_space;
            "*": token_next.char_class = log_char_pkg::cc_star;
            "=": token_next.char_class = log_char_pkg::cc_equals;
            "<": token_next.char_class = log_char_pkg::cc_less;
            "$": token_next.char_class = log_char_pkg::cc_dollar;
            "#": token_next.char_class = log_char_pkg::cc_hash;
            ":": token_next.char_class = log_char_pkg::cc_colon;
            default: token_next.char_class = log_char_pkg::cc_other;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            token.char_class <= log_char_pkg::cc_other;
            token.nibble     <= 4'd0;
        end else begin
            token <= token_next;
        end
    end

    // Digit nibbles stay in their class range, all others stay zero
    a_nibble_matches_class: assert property (
        @(posedge clk) disable iff (reset)
        (token.char_class == log_char_pkg::cc_dec_digit)  ? token.nibble <= 4'd9  :
        (token.char_class == log_char_pkg::cc_hex_letter) ? token.nibble >= 4'd10 :
                                                            token.nibble == 4'd0
    ) else $error("token nibble out of range for its class");

endmodule

// File: src/format_parser.sv
module format_parser (
    input  logic                        clk,
    input  logic                        reset,
    input  log_char_pkg::char_token_t   token,
    output log_record_pkg::parse_step_t step
);

    typedef enum logic [3:0] {
        st_idle,
        st_time_digits,
        st_pc_digits,
        st_colon_spaces,
        st_reg_digits,
        st_mem_open,
        st_addr_digits,
        st_arrow_spaces,
        st_arrow_eq,
        st_data_spaces,
        st_data_digits
    } parse_state_e;

    parse_state_e                 state;
    parse_state_e                 state_next;
    logic [3:0]                   cnt;
    logic [3:0]                   cnt_next;
    log_record_pkg::record_kind_e kind;
    log_record_pkg::record_kind_e kind_next;
    log_record_pkg::parse_step_t  step_next;
    logic                         is_dec;
    logic                         is_hex;
    logic                         dec_full;
    logic                         hex_full;

    assign is_dec   = token.char_class == log_char_pkg::cc_dec_digit;
    assign is_hex   = is_dec || token.char_class == log_char_pkg::cc_hex_letter;
    assign dec_full = cnt == log_record_pkg::DEC_FIELD_MAX_DIGITS;
    assign hex_full = cnt == log_record_pkg::HEX_FIELD_DIGITS;

    ////////////////////////////////////////
    // Next state
    ////////////////////////////////////////

    // Anything not matched below abandons the line
    always_comb begin
        state_next       = st_idle;
        cnt_next         = 4'd0;
        kind_next        = kind;
        step_next.start  = 1'b0;
        step_next.field  = log_record_pkg::field_none;
        step_next.nibble = token.nibble;
        step_next.done   = 1'b0;
        step_next.kind   = kind;

        if (token.char_class == log_char_pkg::cc_caret) begin
            // New line from any point
            state_next      = st_time_digits;
            kind_next       = log_record_pkg::kind_none;
            step_next.start = 1'b1;
        end else begin
            case (state)
                st_time_digits: begin
                    if (is_dec && !dec_full) begin
                        state_next      = st_time_digits;
                        cnt_next        = cnt + 4'd1;
                        step_next.field = log_record_pkg::field_time;
                    end else if (token.char_class == log_char_pkg::cc_at && cnt != 4'd0) begin
                        state_next = st_pc_digits;
                    end
                end
                st_pc_digits: begin
                    if (is_hex && !hex_full) begin
                        state_next      = st_pc_digits;
                        cnt_next        = cnt + 4'd1;
                        step_next.field = log_record_pkg::field_pc;
                    end else if (token.char_class == log_char_pkg::cc_colon && hex_full) begin
                        state_next = st_colon_spaces;
                    end
                end
                st_colon_spaces: begin
                    if (token.char_class == log_char_pkg::cc_space) begin
                        state_next = st_colon_spaces;
                    end else if (token.char_class == log_char_pkg::cc_dollar) begin
                        state_next = st_reg_digits;
                        kind_next  = log_record_pkg::kind_reg_write;
                    end else if (token.char_class == log_char_pkg::cc_star) begin
                        state_next = st_mem_open;
                        kind_next  = log_record_pkg::kind_mem_write;
                    end
                end
                st_reg_digits: begin
                    if (is_dec && !dec_full) begin
                        state_next      = st_reg_digits;
                        cnt_next        = cnt + 4'd1;
                        step_next.field = log_record_pkg::field_target;
                    end else if (cnt != 4'd0) begin
                        if (token.char_class == log_char_pkg::cc_space) begin
                            state_next = st_arrow_spaces;
                        end else if (token.char_class == log_char_pkg::cc_less) begin
                            state_next = st_arrow_eq;
                        end
                    end
                end
                st_mem_open: begin
                    if (is_hex) begin
                        state_next      = st_addr_digits;
                        cnt_next        = 4'd1;
                        step_next.field = log_record_pkg::field_target;
                    end
                end
                st_addr_digits: begin
                    if (is_hex && !hex_full) begin
                        state_next      = st_addr_digits;
                        cnt_next        = cnt + 4'd1;
                        step_next.field = log_record_pkg::field_target;
                    end else if (hex_full) begin
                        if (token.char_class == log_char_pkg::cc_space) begin
                            state_next = st_arrow_spaces;
                        end else if (token.char_class == log_char_pkg::cc_less) begin
                            state_next = st_arrow_eq;
                        end
                    end
                end
                st_arrow_spaces: begin
                    if (token.char_class == log_char_pkg::cc_space) begin
                        state_next = st_arrow_spaces;
                    end else if (token.char_class == log_char_pkg::cc_less) begin
                        state_next = st_arrow_eq;
                    end
                end
                st_arrow_eq: begin
                    if (token.char_class == log_char_pkg::cc_equals) begin
                        state_next = st_data_spaces;
                    end
                end
                st_data_spaces: begin
                    if (token.char_class == log_char_pkg::cc_space) begin
                        state_next = st_data_spaces;
                    end else if (is_hex) begin
                        state_next      = st_data_digits;
                        cnt_next        = 4'd1;
                        step_next.field = log_record_pkg::field_data;
                    end
                end
                st_data_digits: begin
                    if (is_hex && !hex_full) begin
                        state_next      = st_data_digits;
                        cnt_next        = cnt + 4'd1;
                        step_next.field = log_record_pkg::field_data;
                    end else if (token.char_class == log_char_pkg::cc_hash && hex_full) begin
                        // Line accepted, back to idle
                        step_next.done = 1'b1;
                    end
                end
                default: state_next = st_idle;
            endcase
        end
    end

    ////////////////////////////////////////
    // Registers
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            cnt   <= 4'd0;
            kind  <= log_record_pkg::kind_none;
            step  <= '0;
        end else begin
            state <= state_next;
            cnt   <= cnt_next;
            kind  <= kind_next;
            step  <= step_next;
        end
    end

    a_start_done_exclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(step.start && step.done)
    ) else $error("start and done in the same step");

    // Kind must have been latched from the dollar or star
    a_done_has_kind: assert property (
        @(posedge clk) disable iff (reset)
        step.done |-> step.kind != log_record_pkg::kind_none
    ) else $error("done without a record kind");

endmodule

// File: src/field_assembler.sv
module field_assembler (
    input  logic                        clk,
    input  logic                        reset,
    input  log_record_pkg::parse_step_t step,
    output logic                        record_valid,
    output log_record_pkg::log_record_t record
);

    typedef logic [log_record_pkg::TIME_WIDTH-1:0] time_t;

    log_record_pkg::log_record_t work;

    ////////////////////////////////////////
    // Field accumulation
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (step.start) begin
            work <= '0;
        end else begin
            case (step.field)
                log_record_pkg::field_time: begin
                    work.time_value <= work.time_value * time_t'(10) + time_t'(step.nibble);
                end
                log_record_pkg::field_pc: begin
                    work.pc <= {work.pc[27:0], step.nibble};
                end
                log_record_pkg::field_target: begin
                    // Register number is decimal, address is hex
                    if (step.kind == log_record_pkg::kind_reg_write) begin
                        work.target <= work.target * 32'd10 + 32'(step.nibble);
                    end else begin
                        work.target <= {work.target[27:0], step.nibble};
                    end
                end
                log_record_pkg::field_data: begin
                    work.data <= {work.data[27:0], step.nibble};
                end
                default: work <= work;
            endcase
        end
    end

    // Record holds until the next accepted line
    always_ff @(posedge clk) begin
        if (step.done) begin
            record      <= work;
            record.kind <= step.kind;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            record_valid <= 1'b0;
        end else begin
            record_valid <= step.done;
        end
    end

    // A line ends in a hash and the parser then needs a caret
    a_valid_single_cycle: assert property (
        @(posedge clk) disable iff (reset)
        record_valid |=> !record_valid
    ) else $error("record_valid held for two cycles");

endmodule

// File: src/log_checker.sv
module log_checker (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [7:0]                  char,
    output logic                        record_valid,
    output log_record_pkg::log_record_t record
);

    log_char_pkg::char_token_t   token;
    log_record_pkg::parse_step_t step;

    ////////////////////////////////////////
    // Three stage pipeline
    ////////////////////////////////////////

    // Stage 1, byte to class
    char_classifier classifier_i (
        .clk   (clk),
        .reset (reset),
        .char  (char),
        .token (token)
    );

    // Stage 2, line format
    format_parser parser_i (
        .clk   (clk),
        .reset (reset),
        .token (token),
        .step  (step)
    );

    // Stage 3, field values
    field_assembler assembler_i (
        .clk          (clk),
        .reset        (reset),
        .step         (step),
        .record_valid (record_valid),
        .record       (record)
    );

endmodule

// File: bench/log_checker_tb.sv
module log_checker_tb;

    timeunit 1ns;
    timeprecision 1ps;

    logic                        clk;
    logic                        reset;
    logic [7:0]                  char;
    logic                        record_valid;
    log_record_pkg::log_record_t record;

    log_record_pkg::log_record_t exp_q[$];
    int                          due_q[$];
    int                          cycle_no = 0;
    logic [15:0]                 lfsr_state = 16'd285;

    log_checker dut_i (
        .clk          (clk),
        .reset        (reset),
        .char         (char),
        .record_valid (record_valid),
        .record       (record)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////
    // Reporting
    ////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run("field mismatch in record");
        end
    endtask

    ////////////////////////////////////////
    // Line format model
    ////////////////////////////////////////

    function automatic bit is_dec_char(input byte c);
        return c >= "0" && c <= "9";
    endfunction

    function automatic bit is_hex_char(input byte c);
        return is_dec_char(c) || (c >= "a" && c <= "f");
    endfunction

    // Reads a digit run and folds its value, returns the digit count
    function automatic int take_digits(input string s, inout int i, input bit hex,
                                       inout logic [31:0] v);
        int  n;
        byte c;
        n = 0;
        while (i < s.len() && (hex ? is_hex_char(s[i]) : is_dec_char(s[i]))) begin
            c = s[i];
            if (hex) begin
                v = (v << 4) | ((c >= "a") ? c - "a" + 10 : c - "0");
            end else begin
                v = v * 10 + (c - "0");
            end
            i++;
            n++;
        end
        return n;
    endfunction

    function automatic int skip_spaces(input string s, input int i);
        while (i < s.len() && s[i] == " ") begin
            i++;
        end
        return i;
    endfunction

    // Text from caret to hash, returns 1 when the line is legal
    function automatic bit parse_line(input string s, output log_record_pkg::log_record_t r);
        int          i;
        int          n;
        logic [31:0] v;
        r = '0;
        i = 1;
        v = 0;
        n = take_digits(s, i, 1'b0, v);
        if (n < 1 || n > 4 || s[i] != "@") return 0;
        r.time_value = v[13:0];
        i++;
        v = 0;
        if (take_digits(s, i, 1'b1, v) != 8 || s[i] != ":") return 0;
        r.pc = v;
        i = skip_spaces(s, i + 1);
        v = 0;
        if (s[i] == "$") begin
            i++;
            n = take_digits(s, i, 1'b0, v);
            if (n < 1 || n > 4) return 0;
            r.kind = log_record_pkg::kind_reg_write;
        end else if (s[i] == "*") begin
            i++;
            if (take_digits(s, i, 1'b1, v) != 8) return 0;
            r.kind = log_record_pkg::kind_mem_write;
        end else begin
            return 0;
        end
        r.target = v;
        i = skip_spaces(s, i);
        if (s[i] != "<" || s[i+1] != "=") return 0;
        i = skip_spaces(s, i + 2);
        v = 0;
        if (take_digits(s, i, 1'b1, v) != 8) return 0;
        r.data = v;
        return s[i] == "#" && i == s.len() - 1;
    endfunction

    ////////////////////////////////////////
    // Random fields
    ////////////////////////////////////////

    function logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        lsb;
        v = 0;
        for (int k = 0; k < n; k++) begin
            lsb = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (lsb) lfsr_state = lfsr_state ^ 16'hb400;
            v = {v[30:0], lsb};
        end
        return v;
    endfunction

    function string rand_field(input bit hex, input int ndig);
        string s;
        string hex_chars;
        s = "";
        hex_chars = "0123456789abcdef";
        for (int k = 0; k < ndig; k++) begin
            if (hex) s = {s, string'(hex_chars[rand_bits(4)])};
            else s = {s, string'(hex_chars[rand_bits(4) % 10])};
        end
        return s;
    endfunction

    function string rand_spaces();
        string s;
        int    n;
        s = "";
        n = rand_bits(2);
        for (int k = 0; k < n; k++) s = {s, " "};
        return s;
    endfunction

    function string random_line();
        string tgt;
        string t;
        t = rand_field(1'b0, rand_bits(2) + 1);
        if (rand_bits(1)) tgt = {"*", rand_field(1'b1, 8)};
        else tgt = {"$", rand_field(1'b0, rand_bits(2) + 1)};
        return {"^", t, "@", rand_field(1'b1, 8), ":", rand_spaces(), tgt,
                rand_spaces(), "<=", rand_spaces(), rand_field(1'b1, 8), "#"};
    endfunction

    // Inserts a stray character or drops one
    function string corrupt_line(input string s);
        int p;
        p = 1 + rand_bits(6) % (s.len() - 1);
        if (rand_bits(1)) return {s.substr(0, p - 1), "Q", s.substr(p, s.len() - 1)};
        return {s.substr(0, p - 1), s.substr(p + 1, s.len() - 1)};
    endfunction

    ////////////////////////////////////////
    // Drivers and monitor
    ////////////////////////////////////////

    task automatic send_raw(input string s);
        for (int i = 0; i < s.len(); i++) begin
            @(posedge clk);
            char <= s[i];
        end
    endtask

    // Record due 3 edges after the hash is sampled
    task automatic send_line(input string s);
        int                          start;
        log_record_pkg::log_record_t r;
        start = -1;
        for (int i = 0; i < s.len(); i++) begin
            @(posedge clk);
            char <= s[i];
            if (s[i] == "^") begin
                start = i;
            end else if (s[i] == "#" && start >= 0) begin
                if (parse_line(s.substr(start, i), r)) begin
                    exp_q.push_back(r);
                    due_q.push_back(cycle_no + 4);
                end
                start = -1;
            end
        end
    endtask

    always @(negedge clk) begin
        log_record_pkg::log_record_t r;
        int                          due;
        cycle_no++;
        if (record_valid === 1'b1) begin
            assert (exp_q.size() > 0) else abort_run("record_valid with no line accepted");
            r = exp_q.pop_front();
            due = due_q.pop_front();
            compare_field("record_valid cycle", cycle_no, due);
            compare_field("record.kind", record.kind, r.kind);
            compare_field("record.time_value", record.time_value, r.time_value);
            compare_field("record.pc", record.pc, r.pc);
            compare_field("record.target", record.target, r.target);
            compare_field("record.data", record.data, r.data);
        end
    end

    task automatic expect_records();
        int waited;
        waited = 0;
        while (exp_q.size() > 0) begin
            @(negedge clk);
            waited++;
            assert (waited < 50) else abort_run("timeout waiting for record_valid");
        end
    endtask

    task automatic expect_silence(input int span);
        repeat (span) begin
            @(negedge clk);
            assert (record_valid !== 1'b1) else abort_run("record_valid on a rejected line");
        end
    endtask

    task automatic send_malformed(input string s);
        log_record_pkg::log_record_t r;
        assert (!parse_line(s, r)) else abort_run("malformed test line is legal");
        send_raw(s);
        expect_silence(6);
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////

    task automatic test_reg_lines();
        send_line("^7@0040a0bc: $3 <= 0000002a#");
        expect_records();
        send_line("^1234@deadbeef:   $1023   <=  ffffffff#");
        expect_records();
        send_line("^42@00000000:$0<=12345678#");
        expect_records();
    endtask

    task automatic test_mem_lines();
        send_line("^99@00400010: *1000fffc <= cafe0001#");
        expect_records();
        send_line("^3@0badf00d:*00000000  <=0000beef#");
        expect_records();
    endtask

    task automatic test_malformed();
        send_malformed("^12345@00400000: $1 <= 00000001#");
        send_malformed("^1@0040000: $1 <= 00000001#");
        send_malformed("^1@004000000: $1 <= 00000001#");
        send_malformed("^1@00400000 $1 <= 00000001#");
        send_malformed("^1@00400000 : $1 <= 00000001#");
        send_malformed("^1@0040000A: $1 <= 00000001#");
        send_malformed("^1@00400000: $1 < 00000001#");
    endtask

    task automatic test_caret_restart();
        send_line("^12@00400000: $5 <= ^9@00400004: $6 <= 00000010#");
        expect_records();
        expect_silence(6);
    endtask

    task automatic test_random_mix();
        for (int k = 0; k < 20; k++) begin
            if (rand_bits(1)) send_line(corrupt_line(random_line()));
            send_line(random_line());
        end
        expect_records();
        expect_silence(6);
    endtask

    // Spaces held through reset would keep the line open without it
    task automatic test_reset_mid_line();
        send_raw("^5@00400000: $2 ");
        @(posedge clk);
        reset <= 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        send_raw("<= 00000003#");
        expect_silence(10);
    endtask

    initial begin
        reset = 1'b1;
        char  = " ";
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        test_reg_lines();
        test_mem_lines();
        test_malformed();
        test_caret_restart();
        test_random_mix();
        test_reset_mid_line();
        $display("sim passed");
        $finish;
    end

endmodule

// File: tb.f
src/log_char_pkg.sv
src/log_record_pkg.sv
src/char_classifier.sv
src/format_parser.sv
src/field_assembler.sv
src/log_checker.sv
bench/log_checker_tb.sv

// File: Bender.yml
package:
  name: log_checker

sources:
  - src/log_char_pkg.sv
  - src/log_record_pkg.sv
  - src/char_classifier.sv
  - src/format_parser.sv
  - src/field_assembler.sv
  - src/log_checker.sv
  - target: test
    files:
      - bench/log_checker_tb.sv
